/* logic/int_mem_config.svh */
`ifndef INT_MEM_CONFIG_SVH
`define INT_MEM_CONFIG_SVH

// bus word width in bits
`define INT_MEM_DATA_W 32

// cpu byte address width
`define INT_MEM_ADDR_W 16

// sram size as a byte address width
// 12 bits gives 4 KB, i.e. 1024 words
`define INT_MEM_SRAM_ADDR_W 12

// boot rom size as a byte address width
// 8 bits gives 256 bytes, i.e. 64 words
`define INT_MEM_ROM_ADDR_W 8

// data address bit that selects the boot register instead of the sram
`define INT_MEM_B_BIT 15

// length of a software requested cpu reset, in clock cycles
`define INT_MEM_CPU_RST_CYCLES 4

`endif

/* logic/int_mem_pkg.sv */
`include "int_mem_config.svh"

package int_mem_pkg;

   // bus payload types
   typedef logic [`INT_MEM_DATA_W-1:0]   word_t;
   typedef logic [`INT_MEM_DATA_W/8-1:0] strb_t;
   typedef logic [`INT_MEM_ADDR_W-1:0]   addr_t;

   // word indices, byte address minus the two offset bits
   typedef logic [`INT_MEM_SRAM_ADDR_W-3:0] sram_idx_t;
   typedef logic [`INT_MEM_ROM_ADDR_W-3:0]  rom_idx_t;

   localparam int sram_words = 2 ** (`INT_MEM_SRAM_ADDR_W - 2);
   localparam int rom_words  = 2 ** (`INT_MEM_ROM_ADDR_W - 2);

   // boot image sits at the very top of the sram
   localparam sram_idx_t boot_offset = sram_idx_t'(sram_words - rom_words);

   // bit positions in a boot register write
   localparam int BOOT_CLR_BIT = 0;
   localparam int CPU_RST_BIT  = 1;

   // cpu byte address to sram word, shifted onto the boot image while booting
   function automatic sram_idx_t remap_idx(addr_t addr, logic boot);
      sram_idx_t idx;
      idx = addr[`INT_MEM_SRAM_ADDR_W-1:2];
      if (boot) begin
         idx = idx + boot_offset;
      end
      return idx;
   endfunction

endpackage

/* logic/int_mem_data_split.sv */
`timescale 1ns/100ps

`include "int_mem_config.svh"

module int_mem_data_split
   import int_mem_pkg::*;
(
   input  logic      clk_i,
   input  logic      arst_n_i,
   input  logic      boot_i,

   // cpu data bus
   input  logic      d_valid_i,
   input  addr_t     d_addr_i,
   input  word_t     d_wdata_i,
   input  strb_t     d_wstrb_i,
   output word_t     d_rdata_o,
   output logic      d_rvalid_o,
   output logic      d_ready_o,

   // boot register side
   output logic      reg_valid_o,
   output word_t     reg_wdata_o,
   output strb_t     reg_wstrb_o,
   input  word_t     reg_rdata_i,
   input  logic      reg_rvalid_i,

   // sram side
   output logic      ram_valid_o,
   output sram_idx_t ram_idx_o,
   output word_t     ram_wdata_o,
   output strb_t     ram_wstrb_o,
   input  word_t     ram_rdata_i,
   input  logic      ram_rvalid_i
);

   logic sel_reg;
   logic sel_reg_q;

   // both targets accept every cycle
   assign d_ready_o = 1'b1;

   assign sel_reg = d_addr_i[`INT_MEM_B_BIT];

   assign reg_valid_o = d_valid_i & sel_reg;
   assign reg_wdata_o = d_wdata_i;
   assign reg_wstrb_o = d_wstrb_i;

   assign ram_valid_o = d_valid_i & ~sel_reg;
   assign ram_idx_o   = remap_idx(d_addr_i, boot_i);
   assign ram_wdata_o = d_wdata_i;
   assign ram_wstrb_o = d_wstrb_i;

   // remember who got the request so its response comes back next cycle
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         sel_reg_q <= 1'b0;
      end else if (d_valid_i && d_ready_o) begin
         sel_reg_q <= sel_reg;
      end
   end

   assign d_rdata_o  = sel_reg_q ? reg_rdata_i : ram_rdata_i;
   assign d_rvalid_o = sel_reg_q ? reg_rvalid_i : ram_rvalid_i;

endmodule

/* logic/int_mem_boot_ctrl.sv */
`timescale 1ns/100ps

`include "int_mem_config.svh"

module int_mem_boot_ctrl
   import int_mem_pkg::*;
(
   input  logic      clk_i,
   input  logic      arst_n_i,

   // boot register, single word
   input  logic      reg_valid_i,
   input  word_t     reg_wdata_i,
   input  strb_t     reg_wstrb_i,
   output word_t     reg_rdata_o,
   output logic      reg_rvalid_o,

   // boot rom read port
   output logic      rom_valid_o,
   output rom_idx_t  rom_addr_o,
   input  word_t     rom_rdata_i,

   // copy writes towards the sram
   output logic      wr_valid_o,
   output sram_idx_t wr_idx_o,
   output word_t     wr_wdata_o,

   output logic      boot_o,
   output logic      cpu_rst_o
);

   localparam int RST_CNT_W = $clog2(`INT_MEM_CPU_RST_CYCLES + 1);

   typedef enum logic [1:0] {
      st_idle,
      st_copy,
      st_flush,
      st_run
   } state_t;

   state_t         state_q;
   rom_idx_t       rd_idx_q;
   rom_idx_t       wr_k_q;
   logic           wr_pend_q;
   logic           boot_q;
   logic [RST_CNT_W-1:0] rst_cnt_q;
   logic           reg_wr;
   logic           reg_rd;

   // copy fsm: one rom read per cycle, the write trails it by one cycle
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q   <= st_idle;
         rd_idx_q  <= '0;
         wr_pend_q <= 1'b0;
      end else begin
         wr_pend_q <= rom_valid_o;
         case (state_q)
            st_idle: state_q <= st_copy;
            st_copy: begin
               rd_idx_q <= rd_idx_q + 1'b1;
               if (rd_idx_q == rom_idx_t'(rom_words - 1)) begin
                  state_q <= st_flush;
               end
            end
            // last write is on the bus this cycle
            st_flush: state_q <= st_run;
            default: state_q <= st_run;
         endcase
      end
   end

   // rom word index of the read in flight
   always_ff @(posedge clk_i) begin
      wr_k_q <= rd_idx_q;
   end

   assign rom_valid_o = (state_q == st_copy);
   assign rom_addr_o  = rd_idx_q;

   assign wr_valid_o = wr_pend_q;
   assign wr_idx_o   = boot_offset + sram_idx_t'(wr_k_q);
   assign wr_wdata_o = rom_rdata_i;

   assign reg_wr = reg_valid_i & (|reg_wstrb_i);
   assign reg_rd = reg_valid_i & ~(|reg_wstrb_i);

   // boot flag and software reset counter
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         boot_q       <= 1'b1;
         rst_cnt_q    <= '0;
         reg_rvalid_o <= 1'b0;
      end else begin
         reg_rvalid_o <= reg_rd;
         if (reg_wr && reg_wdata_i[BOOT_CLR_BIT]) begin
            boot_q <= 1'b0;
         end
         if (reg_wr && reg_wdata_i[CPU_RST_BIT]) begin
            rst_cnt_q <= RST_CNT_W'(`INT_MEM_CPU_RST_CYCLES);
         end else if (rst_cnt_q != '0) begin
            rst_cnt_q <= rst_cnt_q - 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      reg_rdata_o <= word_t'(boot_q);
   end

   assign boot_o = boot_q;

   // cpu held until the copy is done, or while a requested pulse runs
   assign cpu_rst_o = (state_q != st_run) | (rst_cnt_q != '0);

endmodule

/* logic/int_mem_ibus_merge.sv */
`timescale 1ns/100ps

module int_mem_ibus_merge
   import int_mem_pkg::*;
(
   input  logic      boot_i,

   // cpu instruction bus, reads only
   input  logic      i_valid_i,
   input  addr_t     i_addr_i,
   output word_t     i_rdata_o,
   output logic      i_rvalid_o,
   output logic      i_ready_o,

   // boot copy writer
   input  logic      wr_valid_i,
   input  sram_idx_t wr_idx_i,
   input  word_t     wr_wdata_i,

   // sram instruction port
   output logic      p_valid_o,
   output sram_idx_t p_idx_o,
   output word_t     p_wdata_o,
   output strb_t     p_wstrb_o,
   input  word_t     p_rdata_i,
   input  logic      p_rvalid_i
);

   sram_idx_t cpu_idx;

   assign cpu_idx = remap_idx(i_addr_i, boot_i);

   // copy writer has priority, cpu fetch stalls meanwhile
   assign i_ready_o = ~wr_valid_i;

   always_comb begin
      if (wr_valid_i) begin
         p_valid_o = 1'b1;
         p_idx_o   = wr_idx_i;
         p_wdata_o = wr_wdata_i;
         p_wstrb_o = '1;
      end else begin
         p_valid_o = i_valid_i;
         p_idx_o   = cpu_idx;
         p_wdata_o = '0;
         p_wstrb_o = '0;
      end
   end

   // only reads return data, so the response belongs to the cpu
   assign i_rdata_o  = p_rdata_i;
   assign i_rvalid_o = p_rvalid_i;

endmodule

/* logic/int_mem_sram.sv */
`timescale 1ns/100ps

module int_mem_sram
   import int_mem_pkg::*;
(
   input  logic      clk_i,
   input  logic      arst_n_i,

   // port a, instruction side
   input  logic      a_valid_i,
   input  sram_idx_t a_idx_i,
   input  word_t     a_wdata_i,
   input  strb_t     a_wstrb_i,
   output word_t     a_rdata_o,
   output logic      a_rvalid_o,

   // port b, data side
   input  logic      b_valid_i,
   input  sram_idx_t b_idx_i,
   input  word_t     b_wdata_i,
   input  strb_t     b_wstrb_i,
   output word_t     b_rdata_o,
   output logic      b_rvalid_o
);

   localparam int STRB_W = $bits(strb_t);

   word_t mem [sram_words];

   logic a_wr;
   logic b_wr;
   logic a_blocked;

   assign a_wr = a_valid_i & (|a_wstrb_i);
   assign b_wr = b_valid_i & (|b_wstrb_i);

   // same word written from both sides, data port takes it
   assign a_blocked = b_wr & (a_idx_i == b_idx_i);

   always_ff @(posedge clk_i) begin
      for (int i = 0; i < STRB_W; i++) begin
         if (a_wr && !a_blocked && a_wstrb_i[i]) begin
            mem[a_idx_i][i*8 +: 8] <= a_wdata_i[i*8 +: 8];
         end
         if (b_wr && b_wstrb_i[i]) begin
            mem[b_idx_i][i*8 +: 8] <= b_wdata_i[i*8 +: 8];
         end
      end
   end

   // registered reads, old contents on a read during write
   always_ff @(posedge clk_i) begin
      a_rdata_o <= mem[a_idx_i];
      b_rdata_o <= mem[b_idx_i];
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         a_rvalid_o <= 1'b0;
         b_rvalid_o <= 1'b0;
      end else begin
         a_rvalid_o <= a_valid_i & ~(|a_wstrb_i);
         b_rvalid_o <= b_valid_i & ~(|b_wstrb_i);
      end
   end

endmodule

/* logic/int_mem_top.sv */
`timescale 1ns/100ps

module int_mem_top
   import int_mem_pkg::*;
(
   input  logic     clk_i,
   input  logic     arst_n_i,

   // instruction bus
   input  logic     i_valid_i,
   input  addr_t    i_addr_i,
   output word_t    i_rdata_o,
   output logic     i_rvalid_o,
   output logic     i_ready_o,

   // data bus
   input  logic     d_valid_i,
   input  addr_t    d_addr_i,
   input  word_t    d_wdata_i,
   input  strb_t    d_wstrb_i,
   output word_t    d_rdata_o,
   output logic     d_rvalid_o,
   output logic     d_ready_o,

   // boot rom
   output logic     rom_valid_o,
   output rom_idx_t rom_addr_o,
   input  word_t    rom_rdata_i,

   output logic     boot_o,
   output logic     cpu_rst_o
);

   // data split to boot register
   logic      reg_valid;
   word_t     reg_wdata;
   strb_t     reg_wstrb;
   word_t     reg_rdata;
   logic      reg_rvalid;

   // data split to sram port b
   logic      ram_d_valid;
   sram_idx_t ram_d_idx;
   word_t     ram_d_wdata;
   strb_t     ram_d_wstrb;
   word_t     ram_d_rdata;
   logic      ram_d_rvalid;

   // boot copy writer
   logic      wr_valid;
   sram_idx_t wr_idx;
   word_t     wr_wdata;

   // merge to sram port a
   logic      ram_i_valid;
   sram_idx_t ram_i_idx;
   word_t     ram_i_wdata;
   strb_t     ram_i_wstrb;
   word_t     ram_i_rdata;
   logic      ram_i_rvalid;

   int_mem_data_split i_data_split (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .boot_i      (boot_o),
      .d_valid_i   (d_valid_i),
      .d_addr_i    (d_addr_i),
      .d_wdata_i   (d_wdata_i),
      .d_wstrb_i   (d_wstrb_i),
      .d_rdata_o   (d_rdata_o),
      .d_rvalid_o  (d_rvalid_o),
      .d_ready_o   (d_ready_o),
      .reg_valid_o (reg_valid),
      .reg_wdata_o (reg_wdata),
      .reg_wstrb_o (reg_wstrb),
      .reg_rdata_i (reg_rdata),
      .reg_rvalid_i(reg_rvalid),
      .ram_valid_o (ram_d_valid),
      .ram_idx_o   (ram_d_idx),
      .ram_wdata_o (ram_d_wdata),
      .ram_wstrb_o (ram_d_wstrb),
      .ram_rdata_i (ram_d_rdata),
      .ram_rvalid_i(ram_d_rvalid)
   );

   int_mem_boot_ctrl i_boot_ctrl (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .reg_valid_i (reg_valid),
      .reg_wdata_i (reg_wdata),
      .reg_wstrb_i (reg_wstrb),
      .reg_rdata_o (reg_rdata),
      .reg_rvalid_o(reg_rvalid),
      .rom_valid_o (rom_valid_o),
      .rom_addr_o  (rom_addr_o),
      .rom_rdata_i (rom_rdata_i),
      .wr_valid_o  (wr_valid),
      .wr_idx_o    (wr_idx),
      .wr_wdata_o  (wr_wdata),
      .boot_o      (boot_o),
      .cpu_rst_o   (cpu_rst_o)
   );

   int_mem_ibus_merge i_ibus_merge (
      .boot_i    (boot_o),
      .i_valid_i (i_valid_i),
      .i_addr_i  (i_addr_i),
      .i_rdata_o (i_rdata_o),
      .i_rvalid_o(i_rvalid_o),
      .i_ready_o (i_ready_o),
      .wr_valid_i(wr_valid),
      .wr_idx_i  (wr_idx),
      .wr_wdata_i(wr_wdata),
      .p_valid_o (ram_i_valid),
      .p_idx_o   (ram_i_idx),
      .p_wdata_o (ram_i_wdata),
      .p_wstrb_o (ram_i_wstrb),
      .p_rdata_i (ram_i_rdata),
      .p_rvalid_i(ram_i_rvalid)
   );

   int_mem_sram i_sram (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .a_valid_i (ram_i_valid),
      .a_idx_i   (ram_i_idx),
      .a_wdata_i (ram_i_wdata),
      .a_wstrb_i (ram_i_wstrb),
      .a_rdata_o (ram_i_rdata),
      .a_rvalid_o(ram_i_rvalid),
      .b_valid_i (ram_d_valid),
      .b_idx_i   (ram_d_idx),
      .b_wdata_i (ram_d_wdata),
      .b_wstrb_i (ram_d_wstrb),
      .b_rdata_o (ram_d_rdata),
      .b_rvalid_o(ram_d_rvalid)
   );

endmodule

/* tests/int_mem_assertions.sv */
`timescale 1ns/100ps

module int_mem_assertions
   import int_mem_pkg::*;
(
   input  logic  clk_i,
   input  logic  arst_n_i,
   input  logic  i_valid_i,
   input  logic  i_ready_o,
   input  logic  i_rvalid_o,
   input  logic  d_valid_i,
   input  logic  d_ready_o,
   input  strb_t d_wstrb_i,
   input  logic  d_rvalid_o,
   input  logic  wr_valid_i,
   input  logic  rom_valid_o,
   input  logic  boot_o,
   input  logic  cpu_rst_o
);

   int   fail_cnt;
   logic ran_q;

   initial fail_cnt = 0;

   // set once the cpu has left the boot reset
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ran_q <= 1'b0;
      end else if (!cpu_rst_o) begin
         ran_q <= 1'b1;
      end
   end

   // the instruction bus only reads, so every accepted request answers
   a_i_rvalid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      i_rvalid_o == $past(i_valid_i && i_ready_o))
      else begin
         $error("instruction rvalid does not follow an accepted read by one cycle");
         fail_cnt++;
      end

   a_d_rvalid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      d_rvalid_o == $past(d_valid_i && d_ready_o && d_wstrb_i == '0))
      else begin
         $error("data rvalid does not follow an accepted read by one cycle");
         fail_cnt++;
      end

   // each rom read becomes a copy write one cycle later and stalls fetches
   a_copy_stall: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (wr_valid_i == $past(rom_valid_o)) && !(wr_valid_i && i_ready_o))
      else begin
         $error("copy write not paired with a rom read or instruction bus ready");
         fail_cnt++;
      end

   // rom stays quiet after boot even during a software cpu reset
   a_rom_idle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      ((ran_q || !cpu_rst_o) && !boot_o) |-> !rom_valid_o)
      else begin
         $error("rom read after boot finished");
         fail_cnt++;
      end

endmodule

bind int_mem_top int_mem_assertions i_int_mem_assertions (
   .clk_i      (clk_i),
   .arst_n_i   (arst_n_i),
   .i_valid_i  (i_valid_i),
   .i_ready_o  (i_ready_o),
   .i_rvalid_o (i_rvalid_o),
   .d_valid_i  (d_valid_i),
   .d_ready_o  (d_ready_o),
   .d_wstrb_i  (d_wstrb_i),
   .d_rvalid_o (d_rvalid_o),
   .wr_valid_i (wr_valid),
   .rom_valid_o(rom_valid_o),
   .boot_o     (boot_o),
   .cpu_rst_o  (cpu_rst_o)
);

/* tests/tb_int_mem.sv */
`timescale 1ns/100ps

`include "int_mem_config.svh"

module tb_int_mem
   import int_mem_pkg::*;
();

   localparam int TMO       = 200;
   localparam int RAM_WORDS = 1 << (`INT_MEM_SRAM_ADDR_W - 2);
   localparam int ROM_WORDS = 1 << (`INT_MEM_ROM_ADDR_W - 2);
   localparam addr_t REG_ADDR = addr_t'(1) << `INT_MEM_B_BIT;

   logic     clk_i;
   logic     arst_n_i;
   logic     i_valid_i;
   addr_t    i_addr_i;
   word_t    i_rdata_o;
   logic     i_rvalid_o;
   logic     i_ready_o;
   logic     d_valid_i;
   addr_t    d_addr_i;
   word_t    d_wdata_i;
   strb_t    d_wstrb_i;
   word_t    d_rdata_o;
   logic     d_rvalid_o;
   logic     d_ready_o;
   logic     rom_valid_o;
   rom_idx_t rom_addr_o;
   word_t    rom_rdata_i;
   logic     boot_o;
   logic     cpu_rst_o;

   int          errors;
   logic [31:0] lfsr_q;
   // reference image of the sram
   word_t       model [RAM_WORDS];
   // words never written stay unknown
   bit          known [RAM_WORDS];

   int_mem_top i_int_mem_top (.*);

   always #5 clk_i = ~clk_i;

   function automatic word_t rom_word(input int k);
      return (word_t'(k) * 32'h01010101) ^ 32'hb0070000;
   endfunction

   // rom model answers one cycle after the request
   always @(posedge clk_i) begin
      rom_idx_t k;
      k = rom_addr_o;
      if (rom_valid_o) begin
         #1;
         rom_rdata_i = rom_word(int'(k));
      end
   end

   // galois lfsr stepped once per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
         v = {v[30:0], lfsr_q[0]};
      end
      return v;
   endfunction

   // byte address to sram word with the boot shift applied
   function automatic int ram_word(input addr_t a, input logic boot);
      return ((int'(a) >> 2) + (boot ? RAM_WORDS - ROM_WORDS : 0)) % RAM_WORDS;
   endfunction

   function automatic word_t merge_bytes(input word_t old, input word_t wdata,
                                         input strb_t strb);
      word_t r;
      r = old;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) begin
            r[b*8 +: 8] = wdata[b*8 +: 8];
         end
      end
      return r;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
      errors++;
      $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
   endtask

   task automatic data_access(input addr_t addr, input word_t wdata, input strb_t strb,
                              output word_t rdata);
      int n;
      d_valid_i = 1'b1;
      d_addr_i  = addr;
      d_wdata_i = wdata;
      d_wstrb_i = strb;
      n = 0;
      @(posedge clk_i);
      while (!d_ready_o && n < TMO) begin
         n++;
         @(posedge clk_i);
      end
      if (!d_ready_o) begin
         errors++;
         $display("timeout: data request to %h was never accepted", addr);
      end
      #1;
      d_valid_i = 1'b0;
      d_wstrb_i = '0;
      rdata = 'x;
      if (strb == '0) begin
         n = 0;
         @(posedge clk_i);
         while (!d_rvalid_o && n < TMO) begin
            n++;
            @(posedge clk_i);
         end
         if (!d_rvalid_o) begin
            errors++;
            $display("timeout: no data response for read of %h", addr);
         end
         rdata = d_rdata_o;
         #1;
      end
   endtask

   task automatic fetch(input addr_t addr, output word_t data, output int stalls);
      int n;
      i_valid_i = 1'b1;
      i_addr_i  = addr;
      stalls    = 0;
      n = 0;
      @(posedge clk_i);
      while (!i_ready_o && n < TMO) begin
         stalls++;
         n++;
         @(posedge clk_i);
      end
      if (!i_ready_o) begin
         errors++;
         $display("timeout: instruction read of %h was never accepted", addr);
      end
      #1;
      i_valid_i = 1'b0;
      n = 0;
      @(posedge clk_i);
      while (!i_rvalid_o && n < TMO) begin
         n++;
         @(posedge clk_i);
      end
      if (!i_rvalid_o) begin
         errors++;
         $display("timeout: no response for instruction read of %h", addr);
      end
      data = i_rdata_o;
      #1;
   endtask

   task automatic wait_cpu_run();
      int n;
      n = 0;
      while (cpu_rst_o && n < TMO) begin
         @(posedge clk_i);
         #1;
         n++;
      end
      if (cpu_rst_o) begin
         errors++;
         $display("timeout: cpu reset was never released after the boot copy");
      end
   endtask

   task automatic fetch_during_copy();
      word_t data;
      int    stalls;
      int    n;
      n = 0;
      // issue once the copy writer owns the instruction port
      while (i_ready_o && n < TMO) begin
         @(posedge clk_i);
         #1;
         n++;
      end
      if (i_ready_o) begin
         errors++;
         $display("timeout: boot copy never took the instruction port");
      end
      if (!cpu_rst_o) begin
         errors++;
         $display("cpu reset was already released before the stalled fetch");
      end
      fetch(addr_t'(4 * (ROM_WORDS - 1)), data, stalls);
      if (stalls == 0) begin
         errors++;
         $display("instruction read during the boot copy was never stalled");
      end
      if (data !== rom_word(ROM_WORDS - 1)) begin
         report_mismatch("i_rdata_o", rom_word(ROM_WORDS - 1), data);
      end
   endtask

   task automatic read_boot_image();
      word_t data;
      int    stalls;
      wait_cpu_run();
      if (boot_o !== 1'b1) begin
         report_mismatch("boot_o", 1, boot_o);
      end
      for (int k = 0; k < ROM_WORDS; k++) begin
         fetch(addr_t'(4 * k), data, stalls);
         if (data !== rom_word(k)) begin
            report_mismatch("i_rdata_o", rom_word(k), data);
         end
         model[RAM_WORDS - ROM_WORDS + k] = rom_word(k);
         known[RAM_WORDS - ROM_WORDS + k] = 1'b1;
      end
   endtask

   task automatic write_read_remapped();
      addr_t addr;
      word_t wdata;
      word_t rdata;
      strb_t strb;
      int    idx;
      int    stalls;
      for (int t = 0; t < 8; t++) begin
         addr = addr_t'(rand_bits(16)) & 16'h7ffc;
         idx  = ram_word(addr, 1'b1);
         // fill unknown words first so every byte has a defined value
         if (!known[idx]) begin
            wdata = rand_bits(32);
            data_access(addr, wdata, 4'hf, rdata);
            model[idx] = wdata;
            known[idx] = 1'b1;
         end
         wdata = rand_bits(32);
         strb  = strb_t'(rand_bits(4));
         if (strb == '0) begin
            strb = 4'h1;
         end
         data_access(addr, wdata, strb, rdata);
         model[idx] = merge_bytes(model[idx], wdata, strb);
         data_access(addr, '0, '0, rdata);
         if (rdata !== model[idx]) begin
            report_mismatch("d_rdata_o", model[idx], rdata);
         end
         fetch(addr, rdata, stalls);
         if (rdata !== model[idx]) begin
            report_mismatch("i_rdata_o", model[idx], rdata);
         end
      end
   endtask

   task automatic clear_boot_flag();
      word_t wdata;
      word_t rdata;
      int    stalls;
      data_access(REG_ADDR, '0, '0, rdata);
      if (rdata !== 32'h1) begin
         report_mismatch("d_rdata_o", 32'h1, rdata);
      end
      data_access(REG_ADDR, 32'h1 << BOOT_CLR_BIT, 4'hf, rdata);
      if (boot_o !== 1'b0) begin
         report_mismatch("boot_o", 0, boot_o);
      end
      data_access(REG_ADDR, '0, '0, rdata);
      if (rdata !== 32'h0) begin
         report_mismatch("d_rdata_o", 32'h0, rdata);
      end
      // no remap any more
      for (int k = 0; k < 4; k++) begin
         wdata = rand_bits(32);
         data_access(addr_t'(4 * k), wdata, 4'hf, rdata);
         model[k] = wdata;
         known[k] = 1'b1;
         fetch(addr_t'(4 * k), rdata, stalls);
         if (rdata !== model[k]) begin
            report_mismatch("i_rdata_o", model[k], rdata);
         end
      end
   endtask

   task automatic pulse_cpu_reset();
      word_t rdata;
      int    high;
      int    n;
      if (cpu_rst_o !== 1'b0) begin
         report_mismatch("cpu_rst_o", 0, cpu_rst_o);
      end
      data_access(REG_ADDR, 32'h1 << CPU_RST_BIT, 4'hf, rdata);
      high = 0;
      n = 0;
      while (cpu_rst_o && n < TMO) begin
         high++;
         @(posedge clk_i);
         #1;
         n++;
      end
      if (high != `INT_MEM_CPU_RST_CYCLES) begin
         report_mismatch("cpu_rst_o high cycles", `INT_MEM_CPU_RST_CYCLES, high);
      end
   endtask

   initial begin
      clk_i       = 1'b0;
      arst_n_i    = 1'b0;
      i_valid_i   = 1'b0;
      i_addr_i    = '0;
      d_valid_i   = 1'b0;
      d_addr_i    = '0;
      d_wdata_i   = '0;
      d_wstrb_i   = '0;
      rom_rdata_i = '0;
      errors      = 0;
      lfsr_q      = 32'h5c90;
      repeat (2) @(posedge clk_i);
      #1;
      arst_n_i = 1'b1;

      fetch_during_copy();
      read_boot_image();
      write_read_remapped();
      clear_boot_flag();
      pulse_cpu_reset();

      errors += i_int_mem_top.i_int_mem_assertions.fail_cnt;
      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

/* sources.f */
+incdir+logic
logic/int_mem_pkg.sv
logic/int_mem_data_split.sv
logic/int_mem_boot_ctrl.sv
logic/int_mem_ibus_merge.sv
logic/int_mem_sram.sv
logic/int_mem_top.sv
tests/int_mem_assertions.sv
tests/tb_int_mem.sv

/* Bender.yml */
package:
  name: int_mem

sources:
  - include_dirs:
      - logic
    files:
      - logic/int_mem_pkg.sv
      - logic/int_mem_data_split.sv
      - logic/int_mem_boot_ctrl.sv
      - logic/int_mem_ibus_merge.sv
      - logic/int_mem_sram.sv
      - logic/int_mem_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/int_mem_assertions.sv
      - tests/tb_int_mem.sv
